// File: if_stage.f
hdl/fetch_pkg.sv
hdl/wb_pkg.sv
hdl/if_next_pc.sv
hdl/if_wb_fetch.sv
hdl/if_id_regs.sv
hdl/if_stage.sv
testbench/tb_wb_slave.sv
testbench/tb_if_stage.sv

// File: Makefile
TOP := tb_if_stage

all: run

build:
	verilator --binary --timing --assert -j 0 -f if_stage.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" sim.log || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f if_stage.f --top-module if_stage

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: testbench/tb_if_stage.sv
// testbench for the instruction fetch stage
// table driven redirects against a wishbone slave model, checks the
// first bus address, pc sequence, data, error and ID handshake flags

`timescale 1ns/10ps

module tb_if_stage;

  import fetch_pkg::*;
  import wb_pkg::*;

  localparam int          SEED        = 71017;
  localparam addr_t       ERR_ADDR    = 32'h0000_6008;
  localparam logic [31:0] IMAGE_XOR   = 32'h5A3C_96E1;
  localparam addr_t       DM_HALT     = 32'h1A11_0800;
  localparam addr_t       DM_EXC      = 32'h1A11_0808;
  localparam addr_t       BOOT_BASE   = 32'h0000_1000;
  localparam int          WAIT_LIMIT  = 64;
  localparam int          NUM_ENTRIES = 13;

  // entry modes
  localparam logic [1:0] M_PLAIN = 2'd0;
  localparam logic [1:0] M_OPEN  = 2'd1;
  localparam logic [1:0] M_PMP   = 2'd2;
  localparam logic [1:0] M_STALL = 2'd3;

  // one redirect and the words expected after it
  typedef struct packed {
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_mux;
    exc_cause_t  cause;
    addr_t       tgt;
    logic [31:0] count;
    addr_t       exp_pc;
    logic [1:0]  mode;
  } stim_t;

  stim_t       stim [NUM_ENTRIES];
  int          seed;
  logic        valid_exp;
  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  addr_t       boot_addr;
  logic        req;
  logic        pc_set;
  pc_sel_e     pc_mux;
  exc_pc_sel_e exc_pc_mux;
  exc_cause_t  exc_cause;
  addr_t       branch_target;
  addr_t       csr_mepc;
  addr_t       csr_depc;
  addr_t       csr_mtvec;
  logic        pmp_err_if;
  logic        id_in_ready;
  logic        instr_valid_clear;
  logic        instr_valid_id;
  logic        instr_new_id;
  instr_t      instr_rdata_id;
  addr_t       pc_id;
  logic        instr_fetch_err;
  addr_t       pc_if;
  logic        csr_mtvec_init;
  logic        pc_mismatch_alert;
  logic        if_busy;

  if_stage #(
    .DmHaltAddr      (DM_HALT),
    .DmExceptionAddr (DM_EXC)
  ) uut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .wb_req_o            (wb_req),
    .wb_rsp_i            (wb_rsp),
    .boot_addr_i         (boot_addr),
    .req_i               (req),
    .pc_set_i            (pc_set),
    .pc_mux_i            (pc_mux),
    .exc_pc_mux_i        (exc_pc_mux),
    .exc_cause_i         (exc_cause),
    .branch_target_i     (branch_target),
    .csr_mepc_i          (csr_mepc),
    .csr_depc_i          (csr_depc),
    .csr_mtvec_i         (csr_mtvec),
    .pmp_err_if_i        (pmp_err_if),
    .id_in_ready_i       (id_in_ready),
    .instr_valid_clear_i (instr_valid_clear),
    .instr_valid_id_o    (instr_valid_id),
    .instr_new_id_o      (instr_new_id),
    .instr_rdata_id_o    (instr_rdata_id),
    .pc_id_o             (pc_id),
    .instr_fetch_err_o   (instr_fetch_err),
    .pc_if_o             (pc_if),
    .csr_mtvec_init_o    (csr_mtvec_init),
    .pc_mismatch_alert_o (pc_mismatch_alert),
    .if_busy_o           (if_busy)
  );

  tb_wb_slave #(
    .Seed    (SEED),
    .Pattern (IMAGE_XOR),
    .ErrAddr (ERR_ADDR)
  ) u_slave (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // compare helpers
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic addr_equals(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic instr_equals(input string name, input instr_t got, input instr_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic flag_equals(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      fail_run();
    end
  endtask

  // memory image rule, word is its address xor the pattern
  function automatic instr_t image_word(input addr_t a);
    return a ^ IMAGE_XOR;
  endfunction

  // about three ready cycles in four
  function automatic logic rand_bit();
    return ($random(seed) & 32'h3) != 32'h0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // cycle stepping and waits
  //////////////////////////////////////////////////////////////////////

  // lands 1 ns after the edge, valid flag model checked every cycle
  task automatic next_cycle();
    @(posedge clk);
    #1;
    // inputs still hold what the DUT sampled at the edge
    if (instr_new_id) begin
      valid_exp = 1'b1;
    end else if (instr_valid_clear) begin
      valid_exp = 1'b0;
    end
    flag_equals("instr_valid_id_o", instr_valid_id, valid_exp);
    flag_equals("pc_mismatch_alert_o", pc_mismatch_alert, 1'b0);
    flag_equals("if_busy_o", if_busy, wb_req.stb);
  endtask

  task automatic wait_stb(input logic level);
    int n;
    n = 0;
    while (wb_req.stb !== level) begin
      if (n == WAIT_LIMIT) begin
        $display("timeout at %0t: wishbone stb never went to %0b", $time, level);
        fail_run();
      end
      next_cycle();
      n++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // redirect and accept
  //////////////////////////////////////////////////////////////////////

  task automatic apply_redirect(input stim_t e);
    logic open;
    // background values differ from every target
    boot_addr     = BOOT_BASE;
    branch_target = 32'h0000_0A00;
    csr_mepc      = 32'h0000_0B00;
    csr_depc      = 32'h0000_0C00;
    csr_mtvec     = 32'h0000_0D01;
    case (e.pc_mux)
      PC_BOOT: boot_addr     = e.tgt;
      PC_JUMP: branch_target = e.tgt;
      PC_ERET: csr_mepc      = e.tgt;
      PC_DRET: csr_depc      = e.tgt;
      default: csr_mtvec     = e.tgt;
    endcase
    pc_mux     = e.pc_mux;
    exc_pc_mux = e.exc_mux;
    exc_cause  = e.cause;
    // let a read start so the redirect hits an open transfer
    if (e.mode == M_OPEN) begin
      id_in_ready = 1'b1;
      wait_stb(1'b1);
    end
    id_in_ready = 1'b0;
    open        = wb_req.stb;
    pc_set      = 1'b1;
    #1;
    flag_equals("csr_mtvec_init_o", csr_mtvec_init, e.pc_mux == PC_BOOT);
    next_cycle();
    pc_set = 1'b0;
    #1;
    flag_equals("csr_mtvec_init_o", csr_mtvec_init, 1'b0);
    // stale read finishes first, otherwise cyc rose on the redirect edge
    if (open) begin
      wait_stb(1'b0);
      wait_stb(1'b1);
    end else begin
      flag_equals("wb_req_o.stb", wb_req.stb, 1'b1);
    end
    addr_equals("wb_req_o.adr", wb_req.adr, e.exp_pc);
    if (!open) begin
      next_cycle();
    end
  endtask

  task automatic accept_words(input stim_t e);
    addr_t       pc;
    logic [31:0] got;
    int          cycles;
    logic        err_exp;
    pc          = e.exp_pc;
    got         = 32'd0;
    cycles      = 0;
    id_in_ready = 1'b1;
    while (got < e.count) begin
      if (cycles == e.count * 40 + WAIT_LIMIT) begin
        $display("timeout at %0t: instruction %0d after %h never arrived",
                 $time, got, e.exp_pc);
        fail_run();
      end
      next_cycle();
      cycles++;
      if (instr_new_id) begin
        // pmp input as it stood on the load edge
        err_exp = (pc == ERR_ADDR) || pmp_err_if;
        addr_equals("pc_id_o", pc_id, pc);
        // fetch buffer still holds the word just handed to ID
        addr_equals("pc_if_o", pc_if, pc);
        instr_equals("instr_rdata_id_o", instr_rdata_id, image_word(pc));
        flag_equals("instr_fetch_err_o", instr_fetch_err, err_exp);
        pc  = pc + 32'd4;
        got = got + 32'd1;
      end
      if (e.mode == M_STALL) begin
        id_in_ready       = rand_bit();
        instr_valid_clear = rand_bit();
      end else begin
        id_in_ready = (got < e.count);
      end
      // pmp error only over the second word
      pmp_err_if = (e.mode == M_PMP) && (got == 32'd1);
    end
    id_in_ready       = 1'b0;
    instr_valid_clear = 1'b0;
    pmp_err_if        = 1'b0;
  endtask

  // pc_mux, exc_mux, cause, target, count, first pc, mode
  task automatic fill_table();
    stim[0]  = '{PC_BOOT, EXC_PC_EXC, 6'h00, 32'h0000_2000, 32'd6, 32'h0000_2080, M_PLAIN};
    stim[1]  = '{PC_JUMP, EXC_PC_EXC, 6'h00, 32'h0000_3010, 32'd4, 32'h0000_3010, M_PLAIN};
    stim[2]  = '{PC_ERET, EXC_PC_EXC, 6'h00, 32'h0000_3404, 32'd3, 32'h0000_3404, M_PLAIN};
    stim[3]  = '{PC_DRET, EXC_PC_EXC, 6'h00, 32'h0000_3808, 32'd3, 32'h0000_3808, M_PLAIN};
    stim[4]  = '{PC_EXC, EXC_PC_EXC, 6'h00, 32'h0000_4A51, 32'd3, 32'h0000_4A00, M_PLAIN};
    // external cause 7 lands 7 words above the base
    stim[5]  = '{PC_EXC, EXC_PC_IRQ, 6'h07, 32'h0000_4A00, 32'd3, 32'h0000_4A1C, M_PLAIN};
    // internal flag set, slot 31 whatever the low cause
    stim[6]  = '{PC_EXC, EXC_PC_IRQ, 6'h23, 32'h0000_4A00, 32'd3, 32'h0000_4A7C, M_PLAIN};
    stim[7]  = '{PC_EXC, EXC_PC_DBD, 6'h00, 32'h0000_4A00, 32'd2, DM_HALT, M_PLAIN};
    stim[8]  = '{PC_EXC, EXC_PC_DBG_EXC, 6'h00, 32'h0000_4A00, 32'd2, DM_EXC, M_PLAIN};
    stim[9]  = '{PC_JUMP, EXC_PC_EXC, 6'h00, 32'h0000_5000, 32'd4, 32'h0000_5000, M_OPEN};
    // third word sits on the err address
    stim[10] = '{PC_JUMP, EXC_PC_EXC, 6'h00, 32'h0000_6000, 32'd4, 32'h0000_6000, M_PLAIN};
    stim[11] = '{PC_ERET, EXC_PC_EXC, 6'h00, 32'h0000_6800, 32'd3, 32'h0000_6800, M_PMP};
    stim[12] = '{PC_JUMP, EXC_PC_EXC, 6'h00, 32'h0000_7000, 32'd24, 32'h0000_7000, M_STALL};
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    seed              = SEED;
    valid_exp         = 1'b0;
    clk               = 1'b0;
    rst_n             = 1'b0;
    boot_addr         = BOOT_BASE;
    req               = 1'b0;
    pc_set            = 1'b0;
    pc_mux            = PC_BOOT;
    exc_pc_mux        = EXC_PC_EXC;
    exc_cause         = '0;
    branch_target     = '0;
    csr_mepc          = '0;
    csr_depc          = '0;
    csr_mtvec         = '0;
    pmp_err_if        = 1'b0;
    id_in_ready       = 1'b0;
    instr_valid_clear = 1'b0;
    fill_table();

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    flag_equals("wb_req_o.cyc", wb_req.cyc, 1'b0);
    flag_equals("wb_req_o.stb", wb_req.stb, 1'b0);
    flag_equals("instr_valid_id_o", instr_valid_id, 1'b0);
    flag_equals("instr_new_id_o", instr_new_id, 1'b0);
    flag_equals("csr_mtvec_init_o", csr_mtvec_init, 1'b0);
    flag_equals("pc_mismatch_alert_o", pc_mismatch_alert, 1'b0);

    // fetch request alone must not start the bus
    req = 1'b1;
    repeat (3) begin
      next_cycle();
      flag_equals("wb_req_o.cyc", wb_req.cyc, 1'b0);
    end

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      apply_redirect(stim[i]);
      accept_words(stim[i]);
    end

    // valid holds with ID stalled, drops on clear
    repeat (4) next_cycle();
    flag_equals("instr_valid_id_o", instr_valid_id, 1'b1);
    instr_valid_clear = 1'b1;
    next_cycle();
    instr_valid_clear = 1'b0;
    flag_equals("instr_valid_id_o", instr_valid_id, 1'b0);
    next_cycle();

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: testbench/tb_wb_slave.sv
// wishbone classic slave model for the fetch bus
// answers reads from an address xor image after a random wait,
// one address answers with err instead of ack

`timescale 1ns/10ps

module tb_wb_slave #(
  parameter int              Seed    = 71017,
  parameter wb_pkg::wb_dat_t Pattern = 32'h5A3C_96E1,
  parameter wb_pkg::wb_adr_t ErrAddr = 32'h0000_6008
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  wb_pkg::wb_req_t wb_req_i,
  output wb_pkg::wb_rsp_t wb_rsp_o
);

  import wb_pkg::*;

  int         seed = Seed;
  logic       ack_q;
  logic       err_q;
  wb_dat_t    dat_q;
  logic       pending_q;
  logic [1:0] wait_q;

  // one answer per request, the cycle after it the master drops stb
  always @(posedge clk_i or negedge rst_ni) begin : answer
    logic [31:0] rnd;
    if (!rst_ni) begin
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      dat_q     <= '0;
      pending_q <= 1'b0;
      wait_q    <= 2'd0;
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      if (wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q) begin
        if (!pending_q) begin
          // new request, pick a wait of 0 to 3 cycles
          rnd       = $random(seed);
          pending_q <= 1'b1;
          wait_q    <= rnd[1:0];
        end else if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          pending_q <= 1'b0;
          // image word is the address xor the fill pattern
          dat_q     <= wb_req_i.adr ^ Pattern;
          if (wb_req_i.adr == ErrAddr) begin
            err_q <= 1'b1;
          end else begin
            ack_q <= 1'b1;
          end
        end
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = err_q;
  assign wb_rsp_o.dat = dat_q;

endmodule

// File: hdl/if_stage.sv
// instruction fetch stage top
// next pc select feeds the wishbone fetcher, which feeds the IF-ID
// registers, word aligned 32-bit instructions only

`timescale 1ns/10ps

module if_stage #(
  parameter fetch_pkg::addr_t DmHaltAddr      = 32'h1A110800,
  parameter fetch_pkg::addr_t DmExceptionAddr = 32'h1A110808
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // fetch bus
  output wb_pkg::wb_req_t        wb_req_o,
  input  wb_pkg::wb_rsp_t        wb_rsp_i,

  // control from the core
  input  fetch_pkg::addr_t       boot_addr_i,
  input  logic                   req_i,
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::exc_cause_t  exc_cause_i,
  input  fetch_pkg::addr_t       branch_target_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  input  logic                   pmp_err_if_i,
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,

  // towards ID
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output fetch_pkg::addr_t       pc_id_o,
  output logic                   instr_fetch_err_o,
  output fetch_pkg::addr_t       pc_if_o,
  output logic                   csr_mtvec_init_o,
  output logic                   pc_mismatch_alert_o,
  output logic                   if_busy_o
);

  import fetch_pkg::*;

  addr_t       redirect_addr;
  fetch_word_t fetch_word;
  logic        fetch_valid;
  logic        fetch_ready;
  logic        fetch_busy;
  if_id_t      id;

  if_next_pc #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_next_pc (
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .pc_set_i         (pc_set_i),
    .redirect_addr_o  (redirect_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  if_wb_fetch u_wb_fetch (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .pc_set_i        (pc_set_i),
    .redirect_addr_i (redirect_addr),
    .wb_rsp_i        (wb_rsp_i),
    .word_ready_i    (fetch_ready),
    .wb_req_o        (wb_req_o),
    .word_o          (fetch_word),
    .word_valid_o    (fetch_valid),
    .pc_if_o         (pc_if_o),
    .busy_o          (fetch_busy)
  );

  if_id_regs u_if_id_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .word_i              (fetch_word),
    .word_valid_i        (fetch_valid),
    .pmp_err_if_i        (pmp_err_if_i),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .word_ready_o        (fetch_ready),
    .id_o                (id),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // split the IF-ID record onto the ID ports
  assign instr_rdata_id_o  = id.instr;
  assign pc_id_o           = id.addr;
  assign instr_fetch_err_o = id.err;

  assign if_busy_o = fetch_busy;

endmodule

// File: hdl/if_id_regs.sv
// IF-ID pipeline registers
// loads fetched words when ID is ready, merges bus and pmp errors,
// keeps valid and new flags and checks the pc steps by one word

`timescale 1ns/10ps

module if_id_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fetch_pkg::fetch_word_t word_i,
  input  logic                   word_valid_i,
  input  logic                   pmp_err_if_i,
  input  logic                   id_in_ready_i,
  input  logic                   pc_set_i,
  input  logic                   instr_valid_clear_i,
  output logic                   word_ready_o,
  output fetch_pkg::if_id_t      id_o,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output logic                   pc_mismatch_alert_o
);

  import fetch_pkg::*;

  logic   load;
  logic   err_merged;
  logic   seq_q;
  addr_t  expected_pc;
  if_id_t id_d;

  // a redirect squashes whatever sits in the fetch buffer
  assign word_ready_o = id_in_ready_i & ~pc_set_i;
  assign load         = word_valid_i & word_ready_o;

  assign err_merged = word_i.bus_err | pmp_err_if_i;

  assign id_d.instr = word_i.rdata;
  assign id_d.addr  = word_i.addr;
  assign id_d.err   = err_merged;

  //////////////////////////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      // a load in the clear cycle wins
      instr_valid_id_o <= load | (instr_valid_id_o & ~instr_valid_clear_i);
      instr_new_id_o   <= load;
    end
  end

  // payload, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      id_o <= id_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequential pc check
  //////////////////////////////////////////////////////////////////////

  assign expected_pc = id_o.addr + 32'd4;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q               <= 1'b0;
      pc_mismatch_alert_o <= 1'b0;
    end else begin
      // first word after a redirect or an error is not checked
      if (pc_set_i) begin
        seq_q <= 1'b0;
      end else if (load) begin
        seq_q <= ~err_merged;
      end
      pc_mismatch_alert_o <= load & seq_q & (word_i.addr != expected_pc);
    end
  end

  // fetcher needs a full bus read per word, so new pulses are isolated
  new_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |=> !instr_new_id_o)
    else $error("new instruction flag high two cycles in a row");

endmodule

// File: hdl/if_wb_fetch.sv
// wishbone classic instruction fetcher
// reads words in sequence from the redirect target into a one-entry
// buffer, a redirect mid-transfer lets the open read finish and drops it

`timescale 1ns/10ps

module if_wb_fetch (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   pc_set_i,
  input  fetch_pkg::addr_t       redirect_addr_i,
  input  wb_pkg::wb_rsp_t        wb_rsp_i,
  input  logic                   word_ready_i,
  output wb_pkg::wb_req_t        wb_req_o,
  output fetch_pkg::fetch_word_t word_o,
  output logic                   word_valid_o,
  output fetch_pkg::addr_t       pc_if_o,
  output logic                   busy_o
);

  import fetch_pkg::*;

  // discard waits out a read that a redirect made stale
  typedef enum logic [1:0] {
    S_IDLE,
    S_REQUEST,
    S_DISCARD
  } fetch_state_e;

  fetch_state_e state_q, state_d;
  logic         run_q;
  logic         buf_valid_q;
  fetch_word_t  buf_q;
  addr_t        adr_q, adr_d;
  addr_t        fetch_addr_q, fetch_addr_d;
  logic         bus_done;
  logic         buf_load;
  logic         start_seq;

  // ack or err closes the transfer
  assign bus_done  = wb_rsp_i.ack | wb_rsp_i.err;

  // sequential read only once started, and only into a free buffer
  assign start_seq = req_i & run_q & (~buf_valid_q | word_ready_i);

  //////////////////////////////////////////////////////////////////////
  // bus fsm
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    adr_d        = adr_q;
    fetch_addr_d = fetch_addr_q;
    buf_load     = 1'b0;
    unique case (state_q)
      S_IDLE: begin
        if (pc_set_i && req_i) begin
          // redirect goes straight onto the bus
          state_d      = S_REQUEST;
          adr_d        = redirect_addr_i;
          fetch_addr_d = redirect_addr_i;
        end else if (start_seq) begin
          state_d = S_REQUEST;
          adr_d   = fetch_addr_q;
        end
      end
      S_REQUEST: begin
        if (pc_set_i) begin
          // adr stays put until the slave answers
          fetch_addr_d = redirect_addr_i;
          state_d      = bus_done ? S_IDLE : S_DISCARD;
        end else if (bus_done) begin
          state_d      = S_IDLE;
          buf_load     = 1'b1;
          fetch_addr_d = fetch_addr_q + 32'd4;
        end
      end
      S_DISCARD: begin
        // a second redirect just replaces the target
        if (pc_set_i) begin
          fetch_addr_d = redirect_addr_i;
        end
        if (bus_done) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      run_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // nothing is fetched before the first redirect
      if (pc_set_i && req_i) begin
        run_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    adr_q        <= adr_d;
    fetch_addr_q <= fetch_addr_d;
  end

  //////////////////////////////////////////////////////////////////////
  // one-entry fetch buffer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (pc_set_i) begin
      buf_valid_q <= 1'b0;
    end else if (buf_load) begin
      buf_valid_q <= 1'b1;
    end else if (buf_valid_q && word_ready_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  // data kept even on err, the flag travels with it
  always_ff @(posedge clk_i) begin
    if (buf_load) begin
      buf_q.rdata   <= wb_rsp_i.dat;
      buf_q.addr    <= adr_q;
      buf_q.bus_err <= wb_rsp_i.err;
    end
  end

  assign word_o       = buf_q;
  assign word_valid_o = buf_valid_q;
  assign pc_if_o      = buf_q.addr;

  // cyc and stb move together
  assign wb_req_o.cyc = (state_q != S_IDLE);
  assign wb_req_o.stb = (state_q != S_IDLE);
  assign wb_req_o.adr = adr_q;

  assign busy_o = (state_q != S_IDLE);

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  adr_aligned_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_req_o.stb |-> (!$isunknown(wb_req_o.adr) && (wb_req_o.adr[1:0] == 2'b00)))
    else $error("fetch address unknown or not word aligned");

  redirect_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> req_i)
    else $error("redirect while fetch not requested");

endmodule

// File: hdl/if_next_pc.sv
// next pc selection
// builds the redirect address from the boot base, branch target, csrs
// and the exception vector table, and flags mtvec init on boot

`timescale 1ns/10ps

module if_next_pc #(
  parameter fetch_pkg::addr_t DmHaltAddr      = 32'h1A110800,
  parameter fetch_pkg::addr_t DmExceptionAddr = 32'h1A110808
) (
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       branch_target_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::exc_cause_t  exc_cause_i,
  input  logic                   pc_set_i,
  output fetch_pkg::addr_t       redirect_addr_o,
  output logic                   csr_mtvec_init_o
);

  import fetch_pkg::*;

  addr_t      boot_pc;
  addr_t      exc_base;
  addr_t      exc_pc;
  logic [4:0] irq_vec;

  // boot entry, low bits of the base replaced by the fixed offset
  assign boot_pc  = {boot_addr_i[31:VEC_ALIGN], BOOT_OFFSET};

  // vector table base, low bits of mtvec ignored
  assign exc_base = {csr_mtvec_i[31:VEC_ALIGN], {VEC_ALIGN{1'b0}}};

  // internal interrupts all land on the nmi slot
  assign irq_vec  = exc_cause_i.irq_int ? NMI_VECTOR : exc_cause_i.lower_cause;

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = exc_base;
      // one word per vector slot
      EXC_PC_IRQ:     exc_pc = exc_base + addr_t'({irq_vec, 2'b00});
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = exc_base;
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: redirect_addr_o = boot_pc;
      PC_JUMP: redirect_addr_o = branch_target_i;
      PC_EXC:  redirect_addr_o = exc_pc;
      // back to the trapped instruction
      PC_ERET: redirect_addr_o = csr_mepc_i;
      PC_DRET: redirect_addr_o = csr_depc_i;
      default: redirect_addr_o = boot_pc;
    endcase
  end

  // csr file loads mtvec from the boot base on the boot redirect only
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // no clock here, checked whenever the inputs move
  always_comb begin
    if (!$isunknown(boot_addr_i)) begin
      assert (boot_addr_i[VEC_ALIGN-1:0] == '0)
        else $error("boot address not aligned to the vector table");
    end
    // select must be a real source on every redirect
    if (pc_set_i) begin
      assert (!$isunknown(pc_mux_i) && (pc_mux_i inside {PC_BOOT, PC_JUMP, PC_EXC,
                                                         PC_ERET, PC_DRET}))
        else $error("redirect with unknown pc select");
    end
  end

endmodule

// File: hdl/wb_pkg.sv
// wishbone classic types for the instruction fetch bus
// request and response bundles seen from the master side

package wb_pkg;

  // bus address and data vectors
  typedef logic [31:0] wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  // master to slave, read only so no we, sel or write data
  typedef struct packed {
    logic    cyc;
    logic    stb;
    wb_adr_t adr;
  } wb_req_t;

  // slave to master
  // err ends a transfer the same way ack does
  typedef struct packed {
    logic    ack;
    logic    err;
    wb_dat_t dat;
  } wb_rsp_t;

endpackage

// File: hdl/fetch_pkg.sv
// fetch stage types
// addresses, instruction words, redirect selects, exception causes,
// vector layout constants and the records passed down the fetch chain

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // plain vectors
  //////////////////////////////////////////////////////////////////////

  // byte address, every fetch is word aligned
  typedef logic [31:0] addr_t;

  // one uncompressed instruction
  typedef logic [31:0] instr_t;

  //////////////////////////////////////////////////////////////////////
  // redirect selects
  //////////////////////////////////////////////////////////////////////

  // source of the next pc on a redirect
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // target when pc_sel_e is PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // irq_int marks an internal interrupt, these all share one vector
  typedef struct packed {
    logic       irq_int;
    logic [4:0] lower_cause;
  } exc_cause_t;

  //////////////////////////////////////////////////////////////////////
  // vector layout
  //////////////////////////////////////////////////////////////////////

  // vector table base and boot base are aligned to 2**VEC_ALIGN bytes
  parameter int unsigned VEC_ALIGN = 8;

  // boot entry sits this far above the boot base
  parameter logic [VEC_ALIGN-1:0] BOOT_OFFSET = 8'h80;

  // vector slot taken by every internal interrupt
  parameter logic [4:0] NMI_VECTOR = 5'd31;

  //////////////////////////////////////////////////////////////////////
  // records
  //////////////////////////////////////////////////////////////////////

  // content of the IF-ID registers, err holds bus or pmp error
  typedef struct packed {
    instr_t instr;
    addr_t  addr;
    logic   err;
  } if_id_t;

  // word handed from the bus fetcher to the IF-ID registers
  typedef struct packed {
    instr_t rdata;
    addr_t  addr;
    logic   bus_err;
  } fetch_word_t;

endpackage
